/* tft_pattern_consts.svh */
`ifndef TFT_PATTERN_CONSTS_SVH
`define TFT_PATTERN_CONSTS_SVH

// horizontal timing, in pixel clocks
`define H_SYNC       1
`define H_BACK       45
`define H_ACTIVE     800
`define H_FRONT      210
`define H_TOTAL      (`H_SYNC + `H_BACK + `H_ACTIVE + `H_FRONT)
`define H_CNT_BITS   11    // holds 0..1055

// vertical timing, in lines
`define V_SYNC       1
`define V_BACK       22
`define V_ACTIVE     480
`define V_FRONT      22
`define V_TOTAL      (`V_SYNC + `V_BACK + `V_ACTIVE + `V_FRONT)
`define V_CNT_BITS   10    // holds 0..524

// block grid, 2 columns x 4 rows
`define GRID_COL_W   400
`define GRID_ROW_H   120

// vertical bars, 8 across the active width
`define BAR_W        100

// backlight pwm, period is 2**PWM_BITS clocks
`define PWM_BITS     8

// rgb565 colour codes
`define COLOR_BLACK  16'h0000
`define COLOR_BLUE   16'h001F
`define COLOR_RED    16'hF800
`define COLOR_PURPLE 16'hF81F
`define COLOR_GREEN  16'h07E0
`define COLOR_CYAN   16'h07FF
`define COLOR_YELLOW 16'hFFE0
`define COLOR_WHITE  16'hFFFF

`endif

/* tft_pattern_pkg.sv */
package tft_pattern_pkg;

	// one rgb565 pixel, red in the top bits
	typedef struct packed {
		logic [4:0] red;
		logic [5:0] green;
		logic [4:0] blue;
	} rgb565_t;

	// per-pixel timing from the raster counters
	typedef struct packed {
		logic [9:0] x;           // active-area column
		logic [8:0] y;           // active-area row
		logic       de;
		logic       hs;          // active low
		logic       vs;          // active low
		logic       frame_start; // first clock of a frame
	} tft_timing_t;

	// what actually goes to the panel pins
	typedef struct packed {
		rgb565_t rgb;
		logic    hs;
		logic    vs;
		logic    de;
	} tft_out_t;

	// code 2'b11 is unused and decodes as grid
	typedef enum logic [1:0] {
		MODE_GRID  = 2'd0,
		MODE_BARS  = 2'd1,
		MODE_SOLID = 2'd2
	} pattern_mode_t;

endpackage

/* tft_timing.sv */
`timescale 1ns/1ns
`include "tft_pattern_consts.svh"

module tft_timing import tft_pattern_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	output tft_timing_t timing
);

	// first counter value inside the active area
	localparam logic [`H_CNT_BITS-1:0] H_DE_START = `H_SYNC + `H_BACK;
	localparam logic [`H_CNT_BITS-1:0] H_DE_END   = `H_SYNC + `H_BACK + `H_ACTIVE;
	localparam logic [`H_CNT_BITS-1:0] H_LAST     = `H_TOTAL - 1;
	localparam logic [`V_CNT_BITS-1:0] V_DE_START = `V_SYNC + `V_BACK;
	localparam logic [`V_CNT_BITS-1:0] V_DE_END   = `V_SYNC + `V_BACK + `V_ACTIVE;
	localparam logic [`V_CNT_BITS-1:0] V_LAST     = `V_TOTAL - 1;

	logic [`H_CNT_BITS-1:0] h_cnt;
	logic [`V_CNT_BITS-1:0] v_cnt;
	logic [`H_CNT_BITS-1:0] h_off;
	logic [`V_CNT_BITS-1:0] v_off;
	logic                   h_last;
	logic                   h_act;
	logic                   v_act;
	tft_timing_t            timing_next;

	assign h_last = (h_cnt == H_LAST);
	assign h_act  = (h_cnt >= H_DE_START) && (h_cnt < H_DE_END);
	assign v_act  = (v_cnt >= V_DE_START) && (v_cnt < V_DE_END);
	assign h_off  = h_cnt - H_DE_START; // only meaningful while h_act
	assign v_off  = v_cnt - V_DE_START;

	// raster counters, both start at zero so frame opens with sync
	always_ff @(posedge clk) begin
		if (reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			if (h_last) begin
				h_cnt <= '0;
				if (v_cnt == V_LAST)
					v_cnt <= '0;
				else
					v_cnt <= v_cnt + 1'b1;
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end
		end
	end

	always_comb begin
		timing_next.x           = h_off[9:0];
		timing_next.y           = v_off[8:0];
		timing_next.de          = h_act && v_act;
		timing_next.hs          = !(h_cnt < `H_SYNC); // low during sync
		timing_next.vs          = !(v_cnt < `V_SYNC);
		timing_next.frame_start = (h_cnt == '0) && (v_cnt == '0);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			timing             <= '0;
			timing.hs          <= 1'b1; // syncs idle high
			timing.vs          <= 1'b1;
		end else begin
			timing <= timing_next;
		end
	end

endmodule

/* tft_pattern_gen.sv */
`timescale 1ns/1ns
`include "tft_pattern_consts.svh"

module tft_pattern_gen import tft_pattern_pkg::*; (
	input  logic          clk,
	input  logic          reset,
	input  tft_timing_t   timing,
	input  pattern_mode_t pattern_mode,
	input  rgb565_t       solid_color,
	output rgb565_t       pixel,
	output tft_timing_t   timing_d
);

	pattern_mode_t mode_q;     // mode for the current frame
	rgb565_t       solid_q;
	logic [1:0]    grid_row;
	logic          grid_col;
	logic [2:0]    bar_idx;
	rgb565_t       grid_color;
	rgb565_t       bar_color;
	rgb565_t       color;

	// frame-start latch keeps a frame to a single pattern
	always_ff @(posedge clk) begin
		if (reset)
			mode_q <= MODE_GRID;
		else if (timing.frame_start)
			mode_q <= pattern_mode;
	end

	always_ff @(posedge clk) begin
		if (timing.frame_start)
			solid_q <= solid_color;
	end

	// tile position by comparison
	always_comb begin
		grid_col = (timing.x >= `GRID_COL_W);
		if (timing.y < `GRID_ROW_H)
			grid_row = 2'd0;
		else if (timing.y < 2 * `GRID_ROW_H)
			grid_row = 2'd1;
		else if (timing.y < 3 * `GRID_ROW_H)
			grid_row = 2'd2;
		else
			grid_row = 2'd3;
	end

	always_comb begin
		case ({grid_row, grid_col})
			3'b000:  grid_color = `COLOR_BLACK;
			3'b001:  grid_color = `COLOR_BLUE;
			3'b010:  grid_color = `COLOR_RED;
			3'b011:  grid_color = `COLOR_PURPLE;
			3'b100:  grid_color = `COLOR_GREEN;
			3'b101:  grid_color = `COLOR_CYAN;
			3'b110:  grid_color = `COLOR_YELLOW;
			default: grid_color = `COLOR_WHITE;
		endcase
	end

	// bar index is x / BAR_W, done as a threshold scan
	always_comb begin
		bar_idx = 3'd0;
		for (int i = 1; i < 8; i++) begin
			if (timing.x >= i * `BAR_W)
				bar_idx = i[2:0];
		end
	end

	always_comb begin
		case (bar_idx)
			3'd0:    bar_color = `COLOR_WHITE;
			3'd1:    bar_color = `COLOR_YELLOW;
			3'd2:    bar_color = `COLOR_CYAN;
			3'd3:    bar_color = `COLOR_GREEN;
			3'd4:    bar_color = `COLOR_PURPLE;
			3'd5:    bar_color = `COLOR_RED;
			3'd6:    bar_color = `COLOR_BLUE;
			default: bar_color = `COLOR_BLACK;
		endcase
	end

	always_comb begin
		case (mode_q)
			MODE_BARS:  color = bar_color;
			MODE_SOLID: color = solid_q;
			default:    color = grid_color; // spare code too
		endcase
	end

	always_ff @(posedge clk) begin
		pixel <= color;
	end

	// timing follows the colour through the same stage
	always_ff @(posedge clk) begin
		if (reset) begin
			timing_d    <= '0;
			timing_d.hs <= 1'b1;
			timing_d.vs <= 1'b1;
		end else begin
			timing_d <= timing;
		end
	end

endmodule

/* tft_ctrl.sv */
`timescale 1ns/1ns
`include "tft_pattern_consts.svh"

module tft_ctrl import tft_pattern_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  rgb565_t              pixel,
	input  tft_timing_t          timing_d,
	input  logic [`PWM_BITS-1:0] backlight_duty,
	output tft_out_t             tft,
	output logic                 tft_clk,
	output logic                 tft_pwm
);

	logic [`PWM_BITS-1:0] pwm_cnt;
	tft_out_t             tft_next;

	// blank outside the active area
	always_comb begin
		tft_next.rgb = timing_d.de ? pixel : rgb565_t'('0);
		tft_next.hs  = timing_d.hs;
		tft_next.vs  = timing_d.vs;
		tft_next.de  = timing_d.de;
	end

	// data and syncs leave on the same edge
	always_ff @(posedge clk) begin
		if (reset) begin
			tft.rgb <= '0;
			tft.hs  <= 1'b1;
			tft.vs  <= 1'b1;
			tft.de  <= 1'b0;
		end else begin
			tft <= tft_next;
		end
	end

	// free-running, wraps every 2**PWM_BITS clocks
	always_ff @(posedge clk) begin
		if (reset)
			pwm_cnt <= '0;
		else
			pwm_cnt <= pwm_cnt + 1'b1;
	end

	// each counter value appears once per period, so high time equals duty
	always_ff @(posedge clk) begin
		if (reset)
			tft_pwm <= 1'b0;
		else
			tft_pwm <= (pwm_cnt < backlight_duty);
	end

	assign tft_clk = ~clk; // panel samples on our falling edge

endmodule

/* tft_pattern_top.sv */
`timescale 1ns/1ns
`include "tft_pattern_consts.svh"

module tft_pattern_top import tft_pattern_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  pattern_mode_t        pattern_mode,
	input  rgb565_t              solid_color,
	input  logic [`PWM_BITS-1:0] backlight_duty,
	output tft_out_t             tft,
	output logic                 tft_clk,
	output logic                 tft_pwm
);

	tft_timing_t timing;   // raster position, stage 0
	tft_timing_t timing_d; // aligned with pixel
	rgb565_t     pixel;

	tft_timing u_timing (
		.clk    (clk),
		.reset  (reset),
		.timing (timing)
	);

	tft_pattern_gen u_pattern_gen (
		.clk          (clk),
		.reset        (reset),
		.timing       (timing),
		.pattern_mode (pattern_mode),
		.solid_color  (solid_color),
		.pixel        (pixel),
		.timing_d     (timing_d)
	);

	tft_ctrl u_ctrl (
		.clk            (clk),
		.reset          (reset),
		.pixel          (pixel),
		.timing_d       (timing_d),
		.backlight_duty (backlight_duty),
		.tft            (tft),
		.tft_clk        (tft_clk),
		.tft_pwm        (tft_pwm)
	);

endmodule

/* tft_pattern_tb.sv */
`timescale 1ns/1ns
`include "tft_pattern_consts.svh"

module tft_pattern_tb import tft_pattern_pkg::*; ();

	localparam int          FRAME = `H_TOTAL * `V_TOTAL;
	localparam int          LIMIT = 5 * FRAME; // four checked frames plus one spare
	localparam logic [31:0] SEED  = 32'haaa6a68f;

	logic                 clk = 1'b0;
	logic                 reset;
	pattern_mode_t        pattern_mode;
	rgb565_t              solid_color;
	logic [`PWM_BITS-1:0] backlight_duty;
	tft_out_t             tft;
	logic                 tft_clk;
	logic                 tft_pwm;

	int checks      = 0;
	int errors      = 0;
	int cycles      = 0;
	int frames_done = 0;
	int pwm_windows = 0;
	int clk_phases  = 0;

	// reference model state
	pattern_mode_t mode_h1;     // input seen one negedge ago
	pattern_mode_t mode_h2;     // two negedges back as seen by the frame latch
	pattern_mode_t frame_mode;
	rgb565_t       solid_h1;
	rgb565_t       solid_h2;
	rgb565_t       frame_solid;
	logic          prev_hs  = 1'b1;
	logic          prev_vs  = 1'b1;
	logic          prev_de  = 1'b0;
	logic          in_frame = 1'b0;
	int            x_cnt;
	int            y_cnt;
	int            hs_pulses;
	int            frame_base;

	always #2 clk = ~clk;

	tft_pattern_top u_dut (
		.clk            (clk),
		.reset          (reset),
		.pattern_mode   (pattern_mode),
		.solid_color    (solid_color),
		.backlight_duty (backlight_duty),
		.tft            (tft),
		.tft_clk        (tft_clk),
		.tft_pwm        (tft_pwm)
	);

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("run timed out after %0d cycles before four frames were seen", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	function automatic string mode_name(input pattern_mode_t mode);
		case (mode)
			MODE_GRID:  return "grid";
			MODE_BARS:  return "bars";
			MODE_SOLID: return "solid";
			default:    return "spare";
		endcase
	endfunction

	// tiles run left to right and then top to bottom
	function automatic logic [15:0] grid_ref(input int x, input int y);
		case ((y / `GRID_ROW_H) * 2 + x / `GRID_COL_W)
			0:       return `COLOR_BLACK;
			1:       return `COLOR_BLUE;
			2:       return `COLOR_RED;
			3:       return `COLOR_PURPLE;
			4:       return `COLOR_GREEN;
			5:       return `COLOR_CYAN;
			6:       return `COLOR_YELLOW;
			default: return `COLOR_WHITE;
		endcase
	endfunction

	function automatic logic [15:0] bar_ref(input int x);
		case (x / `BAR_W)
			0:       return `COLOR_WHITE;
			1:       return `COLOR_YELLOW;
			2:       return `COLOR_CYAN;
			3:       return `COLOR_GREEN;
			4:       return `COLOR_PURPLE;
			5:       return `COLOR_RED;
			6:       return `COLOR_BLUE;
			default: return `COLOR_BLACK;
		endcase
	endfunction

	function automatic logic [15:0] expected_color(input pattern_mode_t mode,
			input rgb565_t solid, input int x, input int y);
		case (mode)
			MODE_BARS:  return bar_ref(x);
			MODE_SOLID: return solid;
			default:    return grid_ref(x, y); // spare code shows the grid
		endcase
	endfunction

	task automatic close_frame();
		check("active lines", `V_ACTIVE, y_cnt);
		check("hs pulses", `V_TOTAL, hs_pulses);
		$display("frame %0d, %s mode: %0d failed checks", frames_done,
			mode_name(frame_mode), errors - frame_base);
		frames_done++;
	endtask

	// outputs settle by the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			if (prev_vs && !tft.vs) begin
				if (in_frame)
					close_frame();
				in_frame    = 1'b1;
				frame_mode  = mode_h2;
				frame_solid = solid_h2;
				frame_base  = errors;
				x_cnt       = 0;
				y_cnt       = 0;
				hs_pulses   = 0;
			end
			if (prev_hs && !tft.hs)
				hs_pulses++;
			if (!tft.de) begin
				check("blanking", 32'd0, tft.rgb);
			end else if (in_frame) begin
				check(mode_name(frame_mode),
					expected_color(frame_mode, frame_solid, x_cnt, y_cnt), tft.rgb);
				x_cnt++;
			end
			if (prev_de && !tft.de) begin
				if (in_frame) begin
					check("line width", `H_ACTIVE, x_cnt);
					y_cnt++;
				end
				x_cnt = 0;
			end
		end
		prev_hs  = tft.hs;
		prev_vs  = tft.vs;
		prev_de  = tft.de;
		mode_h2  = mode_h1;
		mode_h1  = pattern_mode;
		solid_h2 = solid_h1;
		solid_h1 = solid_color;
	end

	// panel clock sampled mid-phase and high while clk is low
	always @(clk) begin
		#1;
		clk_phases++;
		check("tft_clk", clk ? 32'd0 : 32'd1, tft_clk);
	end

	// three random changes per frame and the next frame's value in the front porch
	task automatic play_frames(input int mode_base);
		int change [3];
		for (int f = 0; f < 4; f++) begin
			for (int c = 0; c < 3; c++)
				change[c] = $urandom_range(FRAME - 2000, 100);
			for (int i = 0; i < FRAME; i++) begin
				@(posedge clk);
				if (i == change[0] || i == change[1] || i == change[2]) begin
					pattern_mode <= pattern_mode_t'(2'($urandom));
					solid_color  <= 16'($urandom);
				end
				if (i == FRAME - 500 && f < 3) begin
					pattern_mode <= pattern_mode_t'(2'((mode_base + f + 1) % 4));
					solid_color  <= 16'($urandom);
				end
			end
		end
	endtask

	// duty held 512 clocks with the first 256 pwm samples counted
	task automatic sweep_duty();
		logic [31:0]          r;
		logic [`PWM_BITS-1:0] duty;
		int                   highs;
		forever begin
			r    = $urandom;
			duty = r[`PWM_BITS-1:0];
			backlight_duty <= duty;
			@(posedge clk);
			highs = 0;
			repeat (256) begin
				@(negedge clk);
				if (tft_pwm)
					highs++;
			end
			pwm_windows++;
			check("backlight", duty, highs);
			repeat (256) @(posedge clk);
		end
	endtask

	initial begin
		int mode_base;
		void'($urandom(SEED));
		mode_base      = $urandom_range(3, 0); // rotating start covers all four codes
		reset          = 1'b1;
		pattern_mode   = pattern_mode_t'(2'(mode_base));
		solid_color    = 16'($urandom);
		backlight_duty = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		fork
			play_frames(mode_base);
			sweep_duty();
		join_none
		wait (frames_done == 4);
		@(negedge clk);
		$display("backlight: %0d windows of 256 clocks", pwm_windows);
		$display("tft_clk: %0d half cycles compared", clk_phases);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* tft_pattern.f */
+incdir+.
tft_pattern_pkg.sv
tft_timing.sv
tft_pattern_gen.sv
tft_ctrl.sv
tft_pattern_top.sv
tft_pattern_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tft_pattern_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= tft_pattern.f
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := tft_pattern_consts.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source, the header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
